// ==== common/gat_cfg.svh ====
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// number of lanes. any count from 1 up works.
`define GAT_NUM_LANES 4

// sparse word field widths.
`define GAT_COL_W  6
`define GAT_VAL_W  12
`define GAT_NODE_W 10
`define GAT_CNT_W  8

`define GAT_SUM_W 32 // row sums wrap at this width.

`define GAT_CAPTURE_NODE 10

`endif

// ==== common/gat_pkg.sv ====
`default_nettype none
`include "gat_cfg.svh"

package gat_pkg;

  // header view of an incoming sparse word.
  typedef struct packed {
    logic                   is_hdr;
    logic [`GAT_NODE_W-1:0] node;
    logic [`GAT_CNT_W-1:0]  nnz;
  } h_hdr_t;

  // entry view of the same word. is_hdr keeps the header view's bit.
  typedef struct packed {
    logic                         is_hdr;
    logic [`GAT_COL_W-1:0]        col;
    logic signed [`GAT_VAL_W-1:0] val;
  } h_ent_t;

  typedef union packed {
    h_hdr_t hdr;
    h_ent_t ent;
  } h_word_u;

  // one product term handed to a lane.
  typedef struct packed {
    logic signed [`GAT_VAL_W-1:0] val;
    logic signed [`GAT_VAL_W-1:0] wgt;
  } lane_op_t;

  typedef struct packed {
    logic [`GAT_NODE_W-1:0] node;
    logic [`GAT_SUM_W-1:0]  sum;
  } lane_res_t;

  typedef struct packed {
    logic       hdr_seen;
    logic       ent_seen;
    logic       rdy_seen;
    logic       rdy_low_seen;
    logic       res_seen;
    logic       multi_busy_seen;
    logic [1:0] spare;
  } dbg_flags_t;

endpackage

`default_nettype wire

// ==== dv/gat_spmm_chk.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gat_cfg.svh"

module gat_spmm_chk (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      hdr_acc_i,
  input wire logic                      rdy_i,
  input wire logic                      res_vld_i,
  input wire logic [`GAT_NUM_LANES-1:0] busy_i,
  input wire logic [`GAT_NUM_LANES-1:0] done_i
);

  localparam int N = `GAT_NUM_LANES;

  // a second result cycle needs another finished lane behind it.
  assert property (@(posedge clk) disable iff (!rst_n)
    res_vld_i && (done_i == '0) |=> !res_vld_i)
    else $error("res_vld_o stayed high with no lane done");

  // the new row takes the last free lane.
  assert property (@(posedge clk) disable iff (!rst_n)
    hdr_acc_i && ($countones(busy_i & ~done_i) == N - 1) |=> !rdy_i)
    else $error("h_rdy_o still high with every lane taken");

  assert property (@(posedge clk)
    $rose(rst_n) |-> !res_vld_i ##1 !res_vld_i ##1 !res_vld_i)
    else $error("result came out right after reset");

endmodule

bind gat_spmm_top gat_spmm_chk u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .hdr_acc_i (hdr_vld),
  .rdy_i     (h_rdy_o),
  .res_vld_i (res_vld_o),
  .busy_i    (busy),
  .done_i    (done)
);

`default_nettype wire

// ==== dv/gat_spmm_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gat_cfg.svh"

module gat_spmm_tb;

  import gat_pkg::*;

  localparam int ROWS  = 40;
  localparam int BURST = 6; // leading rows sent full length with no gaps.

  logic                  clk;
  logic                  rst_n;
  logic                  h_vld_i;
  h_word_u               h_word_i;
  logic                  wgt_we_i;
  logic [`GAT_COL_W-1:0] wgt_addr_i;
  logic [`GAT_VAL_W-1:0] wgt_data_i;
  logic                  h_rdy_o;
  logic                  res_vld_o;
  lane_res_t             res_o;
  dbg_flags_t            debug_flags_o;
  logic [31:0]           debug_count_o;
  logic [31:0]           debug_capture_o;

  logic [31:0]                  lfsr_q;
  logic signed [`GAT_VAL_W-1:0] wgt_ref [2**`GAT_COL_W];
  logic signed [`GAT_VAL_W-1:0] row_val [ROWS][8];
  logic [`GAT_COL_W-1:0]        row_col [ROWS][8];
  int                           row_nnz [ROWS];
  logic [31:0]                  exp_sum [ROWS];
  int                           seen [ROWS];
  int                           hdr_cyc [ROWS];
  int                           res_cyc [ROWS];
  int   cycles = 0;
  int   limit;
  int   words;
  int   n_res = 0;
  int   rnode;
  int   checks = 0;
  int   errors = 0;
  logic rdy_was_high = 1'b0;
  logic rdy_low_obs = 1'b0;
  logic multi_exp;

  gat_spmm_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .h_vld_i         (h_vld_i),
    .h_word_i        (h_word_i),
    .wgt_we_i        (wgt_we_i),
    .wgt_addr_i      (wgt_addr_i),
    .wgt_data_i      (wgt_data_i),
    .h_rdy_o         (h_rdy_o),
    .res_vld_o       (res_vld_o),
    .res_o           (res_o),
    .debug_flags_o   (debug_flags_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // each signed product is sign extended and summed modulo 2^32.
  function automatic logic [31:0] row_sum(input int r);
    logic [31:0] acc;
    int          prod;
    acc = '0;
    for (int k = 0; k < row_nnz[r]; k++) begin
      prod = int'(row_val[r][k]) * int'(wgt_ref[row_col[r][k]]);
      acc  = acc + 32'(prod);
    end
    return acc;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_word(input h_word_u w);
    h_vld_i  = 1'b1;
    h_word_i = w;
    @(posedge clk);
    #1;
    h_vld_i  = 1'b0;
  endtask

  task automatic send_row(input int r, input bit gaps);
    h_word_u w;
    int      idle;
    w            = '0;
    w.hdr.is_hdr = 1'b1;
    w.hdr.node   = `GAT_NODE_W'(r);
    w.hdr.nnz    = `GAT_CNT_W'(row_nnz[r]);
    while (!h_rdy_o) begin // hold the header until a lane is free.
      @(posedge clk);
      #1;
    end
    hdr_cyc[r] = cycles;
    drive_word(w);
    for (int k = 0; k < row_nnz[r]; k++) begin
      idle = gaps ? int'(rand_bits(2)) : 0;
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
      w            = '0;
      w.ent.col    = row_col[r][k];
      w.ent.val    = row_val[r][k];
      drive_word(w);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("simulation timed out after %0d cycles with %0d results", cycles, n_res);
      $display("Test FAILED");
      $finish;
    end
  end

  // outputs are sampled mid cycle.
  always @(negedge clk) begin
    if (rst_n) begin
      if (h_rdy_o) rdy_was_high = 1'b1;
      else if (rdy_was_high) rdy_low_obs = 1'b1;
      if (res_vld_o) begin
        n_res++;
        checks++;
        assert (res_o.node < ROWS) else begin
          errors++;
          $display("a result came back for node %0d, which was never sent", res_o.node);
        end
        if (res_o.node < ROWS) begin
          rnode          = int'(res_o.node);
          seen[rnode]    = seen[rnode] + 1;
          res_cyc[rnode] = cycles;
          check_val($sformatf("sum of node %0d", rnode), res_o.sum, exp_sum[rnode]);
        end
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    h_vld_i    = 1'b0;
    h_word_i   = '0;
    wgt_we_i   = 1'b0;
    wgt_addr_i = '0;
    wgt_data_i = '0;
    lfsr_q     = 32'h3d260974;
    words      = 0;
    for (int a = 0; a < 2**`GAT_COL_W; a++) begin
      wgt_ref[a] = `GAT_VAL_W'(rand_bits(`GAT_VAL_W));
    end
    for (int r = 0; r < ROWS; r++) begin
      row_nnz[r] = (r < BURST) ? 7 : int'(rand_bits(3));
      for (int k = 0; k < row_nnz[r]; k++) begin
        row_col[r][k] = `GAT_COL_W'(rand_bits(`GAT_COL_W));
        row_val[r][k] = `GAT_VAL_W'(rand_bits(`GAT_VAL_W));
      end
      exp_sum[r] = row_sum(r);
      seen[r]    = 0;
      words      = words + 1 + row_nnz[r];
    end
    limit = 25 * words + 200;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_val("debug flags after reset", 32'(debug_flags_o), 32'h0);
    check_val("result count after reset", debug_count_o, 32'h0);
    check_val("captured sum after reset", debug_capture_o, 32'h0);
    check_val("h_rdy_o at reset release", 32'(h_rdy_o), 32'd0);
    @(posedge clk);
    #1;
    check_val("h_rdy_o one cycle after reset", 32'(h_rdy_o), 32'd1);

    for (int a = 0; a < 2**`GAT_COL_W; a++) begin
      wgt_we_i   = 1'b1;
      wgt_addr_i = `GAT_COL_W'(a);
      wgt_data_i = wgt_ref[a];
      @(posedge clk);
      #1;
    end
    wgt_we_i = 1'b0;

    for (int r = 0; r < ROWS; r++) begin
      send_row(r, r >= BURST);
    end
    while (n_res < ROWS) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
    #1;

    // two rows overlap when their lanes are busy in the same cycle.
    multi_exp = 1'b0;
    for (int i = 0; i < ROWS; i++) begin
      for (int j = i + 1; j < ROWS; j++) begin
        if (hdr_cyc[i] + 2 <= res_cyc[j] - 1 && hdr_cyc[j] + 2 <= res_cyc[i] - 1) begin
          multi_exp = 1'b1;
        end
      end
    end
    for (int r = 0; r < ROWS; r++) begin
      check_val($sformatf("report count of node %0d", r), 32'(seen[r]), 32'd1);
    end
    check_val("result count", debug_count_o, 32'(ROWS));
    check_val("captured sum", debug_capture_o, exp_sum[`GAT_CAPTURE_NODE]);
    check_val("hdr_seen", 32'(debug_flags_o.hdr_seen), 32'd1);
    check_val("ent_seen", 32'(debug_flags_o.ent_seen), 32'd1);
    check_val("rdy_seen", 32'(debug_flags_o.rdy_seen), 32'd1);
    check_val("res_seen", 32'(debug_flags_o.res_seen), 32'd1);
    check_val("rdy_low_seen", 32'(debug_flags_o.rdy_low_seen), 32'(rdy_low_obs));
    check_val("multi_busy_seen", 32'(debug_flags_o.multi_busy_seen), 32'(multi_exp));
    check_val("spare flag bits", 32'(debug_flags_o.spare), 32'd0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gat_spmm_top.f ====
+incdir+common
common/gat_pkg.sv
spmm/row_dispatcher.sv
spmm/sppe.sv
spmm/result_drain.sv
verilog/gat_debugger.sv
verilog/gat_spmm_top.sv
dv/gat_spmm_chk.sv
dv/gat_spmm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run the testbench.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module gat_spmm_tb -f gat_spmm_top.f -o gat_spmm_sim \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/gat_spmm_sim)
echo "$out"
echo "$out" | grep -qx "Test OK" && exit 0 || exit 1

// ==== spmm/result_drain.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gat_cfg.svh"

module result_drain (
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,
  input  wire logic [`GAT_NUM_LANES-1:0]                done_i,
  input  wire gat_pkg::lane_res_t [`GAT_NUM_LANES-1:0]  lane_res_i,
  output logic [`GAT_NUM_LANES-1:0]                     ack_o,
  output logic                                          res_vld_o,
  output gat_pkg::lane_res_t                            res_o
);

  import gat_pkg::*;

  localparam int N      = `GAT_NUM_LANES;
  localparam int LANE_W = (N > 1) ? $clog2(N) : 1;

  logic [LANE_W-1:0] ptr; // last lane served.
  logic [LANE_W-1:0] grant;
  logic              grant_v;

  // search starts one past the last lane served.
  always_comb begin
    int unsigned idx;
    grant_v = 1'b0;
    grant   = ptr;
    for (int i = 1; i <= N; i++) begin
      idx = (int'(ptr) + i) % N;
      if (!grant_v && done_i[idx]) begin
        grant_v = 1'b1;
        grant   = LANE_W'(idx);
      end
    end
  end

  always_comb begin
    ack_o = '0;
    if (grant_v) ack_o[grant] = 1'b1; // lane drops done on this edge.
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr       <= LANE_W'(N - 1);
      res_vld_o <= 1'b0;
    end else begin
      res_vld_o <= grant_v;
      if (grant_v) ptr <= grant;
    end
  end

  always_ff @(posedge clk) begin
    if (grant_v) res_o <= lane_res_i[grant];
  end

endmodule

`default_nettype wire

// ==== spmm/row_dispatcher.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gat_cfg.svh"

module row_dispatcher (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         h_vld_i,
  input  wire gat_pkg::h_word_u             h_word_i,
  input  wire logic                         wgt_we_i,
  input  wire logic [`GAT_COL_W-1:0]        wgt_addr_i,
  input  wire logic [`GAT_VAL_W-1:0]        wgt_data_i,
  input  wire logic [`GAT_NUM_LANES-1:0]    busy_i,
  output logic                              h_rdy_o,
  output logic [`GAT_NUM_LANES-1:0]         start_o,
  output gat_pkg::h_hdr_t                   start_hdr_o,
  output logic [`GAT_NUM_LANES-1:0]         op_vld_o,
  output gat_pkg::lane_op_t                 op_o,
  output logic                              ent_vld_o
);

  import gat_pkg::*;

  localparam int N      = `GAT_NUM_LANES;
  localparam int LANE_W = (N > 1) ? $clog2(N) : 1;

  logic signed [`GAT_VAL_W-1:0] wgt_mem [2**`GAT_COL_W];

  logic                  rdy_en;
  logic                  row_act; // entries of the current row still to come.
  logic [LANE_W-1:0]     tgt;
  logic [`GAT_CNT_W-1:0] remain;
  logic [N-1:0]          taken;
  logic [N-1:0]          free;
  logic [LANE_W-1:0]     pick;
  logic                  hdr_acc;
  logic                  ent_acc;

  // a lane is taken from the header edge until its busy level shows up.
  always_comb begin
    taken = busy_i | start_o;
    if (row_act) begin
      taken[tgt] = 1'b1;
    end
  end

  assign free = ~taken;

  // lowest index wins.
  always_comb begin
    pick = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (free[i]) pick = LANE_W'(i);
    end
  end

  assign h_rdy_o = rdy_en & (|free);
  assign hdr_acc = h_vld_i & h_word_i.hdr.is_hdr & h_rdy_o;
  assign ent_acc = h_vld_i & ~h_word_i.ent.is_hdr & row_act;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_en   <= 1'b0;
      start_o  <= '0;
      op_vld_o <= '0;
      row_act  <= 1'b0;
      tgt      <= '0;
      remain   <= '0;
    end else begin
      rdy_en   <= 1'b1;
      start_o  <= '0;
      op_vld_o <= '0;
      if (hdr_acc) begin
        start_o[pick] <= 1'b1;
        tgt           <= pick;
        remain        <= h_word_i.hdr.nnz;
        row_act       <= (h_word_i.hdr.nnz != '0); // empty rows need no entries.
      end else if (ent_acc) begin
        op_vld_o[tgt] <= 1'b1;
        remain        <= remain - 1'b1;
        if (remain == `GAT_CNT_W'(1)) row_act <= 1'b0;
      end
    end
  end

  // weight lookup happens in the entry cycle, op leaves registered.
  always_ff @(posedge clk) begin
    if (wgt_we_i) wgt_mem[wgt_addr_i] <= wgt_data_i;
    if (hdr_acc) start_hdr_o <= h_word_i.hdr;
    if (ent_acc) begin
      op_o.val <= h_word_i.ent.val;
      op_o.wgt <= wgt_mem[h_word_i.ent.col];
    end
  end

  assign ent_vld_o = |op_vld_o;

endmodule

`default_nettype wire

// ==== spmm/sppe.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gat_cfg.svh"

module sppe (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              start_i,
  input  wire gat_pkg::h_hdr_t   hdr_i,
  input  wire logic              op_vld_i,
  input  wire gat_pkg::lane_op_t op_i,
  input  wire logic              ack_i,
  output logic                   busy_o,
  output logic                   done_o,
  output gat_pkg::lane_res_t     res_o
);

  import gat_pkg::*;

  localparam int PROD_W = 2 * `GAT_VAL_W;

  logic [`GAT_CNT_W-1:0]    cnt;
  logic signed [PROD_W-1:0] prod;
  logic [`GAT_SUM_W-1:0]    prod_ext;
  logic                     op_take;

  assign prod     = op_i.val * op_i.wgt;
  assign prod_ext = {{(`GAT_SUM_W - PROD_W){prod[PROD_W-1]}}, prod};
  assign op_take  = op_vld_i & busy_o & ~done_o; // ops past the count are dropped.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt    <= '0;
    end else if (ack_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end else if (start_i) begin
      busy_o <= 1'b1;
      done_o <= (hdr_i.nnz == '0);
      cnt    <= hdr_i.nnz;
    end else if (op_take) begin
      cnt <= cnt - 1'b1;
      if (cnt == `GAT_CNT_W'(1)) begin
        done_o <= 1'b1;
      end
    end
  end

  // result stays put until the drain takes it.
  always_ff @(posedge clk) begin
    if (start_i) begin
      res_o.node <= hdr_i.node;
      res_o.sum  <= '0;
    end else if (op_take) begin
      res_o.sum <= res_o.sum + prod_ext;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gat_debugger.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gat_cfg.svh"

module gat_debugger (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      hdr_vld_i,
  input  wire logic                      ent_vld_i,
  input  wire logic                      rdy_i,
  input  wire logic [`GAT_NUM_LANES-1:0] busy_i,
  input  wire logic                      res_vld_i,
  input  wire gat_pkg::lane_res_t        res_i,
  output gat_pkg::dbg_flags_t            flags_o,
  output logic [31:0]                    count_o,
  output logic [31:0]                    capture_o
);

  import gat_pkg::*;

  dbg_flags_t flags;
  dbg_flags_t flags_reg;
  logic [31:0] count;
  logic [31:0] count_reg;
  logic [31:0] capture;
  logic [31:0] capture_reg;
  logic        multi_busy;
  logic        cap_hit;

  assign multi_busy = ($countones(busy_i) >= 2);
  assign cap_hit    = res_vld_i && (res_i.node == `GAT_NODE_W'(`GAT_CAPTURE_NODE));

  assign flags.hdr_seen        = (hdr_vld_i) ? 1'b1 : flags_reg.hdr_seen;
  assign flags.ent_seen        = (ent_vld_i) ? 1'b1 : flags_reg.ent_seen;
  assign flags.rdy_seen        = (rdy_i)     ? 1'b1 : flags_reg.rdy_seen;
  // only a drop after ready first came up counts.
  assign flags.rdy_low_seen    = (!rdy_i && flags_reg.rdy_seen) ? 1'b1 : flags_reg.rdy_low_seen;
  assign flags.res_seen        = (res_vld_i)  ? 1'b1 : flags_reg.res_seen;
  assign flags.multi_busy_seen = (multi_busy) ? 1'b1 : flags_reg.multi_busy_seen;
  assign flags.spare           = 2'b00;

  assign count   = (res_vld_i) ? (count_reg + 1'b1) : count_reg;
  assign capture = (cap_hit) ? 32'(res_i.sum) : capture_reg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_reg   <= '0;
      count_reg   <= '0;
      capture_reg <= '0;
    end else begin
      flags_reg   <= flags;
      count_reg   <= count;
      capture_reg <= capture;
    end
  end

  assign flags_o   = flags_reg;
  assign count_o   = count_reg;
  assign capture_o = capture_reg;

endmodule

`default_nettype wire

// ==== verilog/gat_spmm_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gat_cfg.svh"

module gat_spmm_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  h_vld_i,
  input  wire gat_pkg::h_word_u      h_word_i,
  input  wire logic                  wgt_we_i,
  input  wire logic [`GAT_COL_W-1:0] wgt_addr_i,
  input  wire logic [`GAT_VAL_W-1:0] wgt_data_i,
  output logic                       h_rdy_o,
  output logic                       res_vld_o,
  output gat_pkg::lane_res_t         res_o,
  output gat_pkg::dbg_flags_t        debug_flags_o,
  output logic [31:0]                debug_count_o,
  output logic [31:0]                debug_capture_o
);

  import gat_pkg::*;

  localparam int N = `GAT_NUM_LANES;

  logic [N-1:0]      busy;
  logic [N-1:0]      done;
  logic [N-1:0]      start;
  logic [N-1:0]      op_vld;
  logic [N-1:0]      ack;
  h_hdr_t            start_hdr;
  lane_op_t          op;
  lane_res_t [N-1:0] lane_res;
  logic              ent_vld;
  logic              hdr_vld;

  assign hdr_vld = h_vld_i & h_word_i.hdr.is_hdr & h_rdy_o; // accepted headers only.

  row_dispatcher u_dispatcher (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_vld_i     (h_vld_i),
    .h_word_i    (h_word_i),
    .wgt_we_i    (wgt_we_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .busy_i      (busy),
    .h_rdy_o     (h_rdy_o),
    .start_o     (start),
    .start_hdr_o (start_hdr),
    .op_vld_o    (op_vld),
    .op_o        (op),
    .ent_vld_o   (ent_vld)
  );

  // start header and op are shared, per-lane strobes pick the lane.
  for (genvar k = 0; k < N; k++) begin : g_lane
    sppe u_sppe (
      .clk      (clk),
      .rst_n    (rst_n),
      .start_i  (start[k]),
      .hdr_i    (start_hdr),
      .op_vld_i (op_vld[k]),
      .op_i     (op),
      .ack_i    (ack[k]),
      .busy_o   (busy[k]),
      .done_o   (done[k]),
      .res_o    (lane_res[k])
    );
  end

  result_drain u_drain (
    .clk        (clk),
    .rst_n      (rst_n),
    .done_i     (done),
    .lane_res_i (lane_res),
    .ack_o      (ack),
    .res_vld_o  (res_vld_o),
    .res_o      (res_o)
  );

  gat_debugger u_debugger (
    .clk       (clk),
    .rst_n     (rst_n),
    .hdr_vld_i (hdr_vld),
    .ent_vld_i (ent_vld),
    .rdy_i     (h_rdy_o),
    .busy_i    (busy),
    .res_vld_i (res_vld_o),
    .res_i     (res_o),
    .flags_o   (debug_flags_o),
    .count_o   (debug_count_o),
    .capture_o (debug_capture_o)
  );

endmodule

`default_nettype wire
